//--- access_arbiter.sv
////////////////////////////////////////
// Access arbiter
// Picks fetch or data for the memory slot,
// stalls fetch, tags every issued read
////////////////////////////////////////

`timescale 1ns/10ps

module access_arbiter (
    input  logic              f_en,
    input  mem_pkg::addr_t    f_addr,
    input  logic              d_en,
    input  logic              d_wr,
    input  mem_pkg::addr_t    d_addr,
    input  mem_pkg::word_t    d_wdata,
    output logic              f_stall,
    mem_req_if.arb            req,
    output logic              rd_issue,
    output mem_pkg::src_tag_t rd_tag
);
    import mem_pkg::*;

    // Winner of this cycle
    logic data_win;
    logic fetch_win;

    ////////////////////////////////////////
    // Grant
    ////////////////////////////////////////

    // Data port has fixed priority
    // load and store stalls cost more than a fetch bubble
    assign data_win  = d_en;
    assign fetch_win = f_en && !d_en;

    // Fetch holds its strobe while the data port owns the slot
    assign f_stall = f_en && d_en;

    ////////////////////////////////////////
    // Access to memory
    ////////////////////////////////////////

    always_comb begin
        req.enable = data_win || fetch_win;
        req.wr     = 1'b0;
        req.addr   = f_addr;
        req.wdata  = '0;
        rd_issue   = fetch_win;
        // Fetch reads carry tag 0
        rd_tag     = src_tag_t'(0);
        if (data_win) begin
            req.wr    = d_wr;
            req.addr  = d_addr;
            req.wdata = d_wdata;
            // Stores produce no response
            rd_issue  = !d_wr;
            rd_tag    = src_tag_t'(1);
        end
    end

endmodule

//--- data_memory.sv
////////////////////////////////////////
// Data memory
// Unified word array, one-cycle writes,
// reads through a four-stage pipeline
////////////////////////////////////////

`timescale 1ns/10ps

module data_memory (
    input  logic           clk,
    input  logic           rst,
    mem_req_if.mem         req,
    output mem_pkg::word_t rdata,
    output logic           rvalid
);
    import mem_pkg::*;

    // Storage, one entry per 16-bit word
    word_t mem [2**word_idx_w];

    // Set once the image has been loaded
    logic loaded = 1'b0;

    // Word index from address bits 15 to 1
    word_idx_t idx;

    // Read issued this cycle
    logic  rd_hit;
    word_t rd_word;

    // Read pipeline, last stage drives the outputs
    word_t                   data_pipe [read_latency];
    logic [read_latency-1:0] valid_pipe;

    assign idx     = req.addr[addr_w-1:1];
    assign rd_hit  = req.enable && !req.wr;
    // Zero when idle keeps the pipe clean in waves
    assign rd_word = rd_hit ? mem[idx] : '0;

    ////////////////////////////////////////
    // Image load and writes
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            // Load only on the first reset, later resets keep contents
            if (!loaded) begin
                $readmemh(init_file, mem);
                loaded <= 1'b1;
            end
        end else if (req.enable && req.wr) begin
            // Visible to any read from the next cycle on
            mem[idx] <= req.wdata;
        end
    end

    ////////////////////////////////////////
    // Read latency pipeline
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < read_latency; i++) begin
                data_pipe[i] <= '0;
            end
            valid_pipe <= '0;
        end else begin
            // Stage 0 captures the array word
            data_pipe[0]  <= rd_word;
            valid_pipe[0] <= rd_hit;
            // Then shift one stage per cycle
            for (int i = 1; i < read_latency; i++) begin
                data_pipe[i]  <= data_pipe[i-1];
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    // Response appears read_latency cycles after the access
    assign rdata  = data_pipe[read_latency-1];
    assign rvalid = valid_pipe[read_latency-1];

endmodule

//--- list.f
mem_pkg.sv
mem_req_if.sv
data_memory.sv
access_arbiter.sv
response_router.sv
mem_subsys.sv
mem_subsys_props.sv
tb_mem_subsys.sv

//--- mem_init.hex
// One 16-bit word per line in hex, word index 0 upward
// Byte address of each word is twice its line number
0A11
1B22
2C33
3D44
4E55
5F66
6071
7182
8293
93A4
A4B5
B5C6
C6D7
D7E8
E8F9
F90A
0A1B
1B2C
2C3D
3D4E
4E5F
5F60
6072
7183

//--- mem_pkg.sv
////////////////////////////////////////
// Memory subsystem package
// Widths, read latency and vector types
// shared by the memory side of the core
////////////////////////////////////////

package mem_pkg;

    ////////////////////////////////////////
    // Widths and timing
    ////////////////////////////////////////

    // Byte address, bit 0 ignored by the word array
    localparam int addr_w = 16;
    // One memory word
    localparam int data_w = 16;
    // Cycles from accepted read to response
    localparam int read_latency = 4;
    // Word index drops the byte bit
    localparam int word_idx_w = addr_w - 1;

    // Image loaded at the first reset
    localparam string init_file = "mem_init.hex";

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    typedef logic [addr_w-1:0]     addr_t;
    typedef logic [data_w-1:0]     word_t;
    typedef logic [word_idx_w-1:0] word_idx_t;

    // Read source, 0 is fetch and 1 is data
    typedef logic [0:0] src_tag_t;

endpackage

//--- mem_req_if.sv
////////////////////////////////////////
// Memory request interface
// One access per cycle, arbiter to memory
////////////////////////////////////////

`timescale 1ns/10ps

interface mem_req_if;
    import mem_pkg::*;

    // Access strobe, no handshake
    logic  enable;
    // High for a write, low for a read
    logic  wr;
    // Byte address of the access
    addr_t addr;
    // Word to store on a write
    word_t wdata;

    // Arbiter side drives the access
    modport arb (output enable, wr, addr, wdata);

    // Memory side takes every enabled cycle
    modport mem (input enable, wr, addr, wdata);

endinterface

//--- mem_subsys.sv
////////////////////////////////////////
// Memory subsystem top
// Arbiter, word memory and response router
// behind fetch and data ports
////////////////////////////////////////

`timescale 1ns/10ps

module mem_subsys (
    input  logic           clk,
    input  logic           rst,
    // Instruction fetch port, read only
    input  logic           f_en,
    input  mem_pkg::addr_t f_addr,
    output logic           f_stall,
    output mem_pkg::word_t f_rdata,
    output logic           f_valid,
    // Data port, loads and stores
    input  logic           d_en,
    input  logic           d_wr,
    input  mem_pkg::addr_t d_addr,
    input  mem_pkg::word_t d_wdata,
    output mem_pkg::word_t d_rdata,
    output logic           d_valid
);
    import mem_pkg::*;

    // Granted access into the memory
    mem_req_if req_bus ();

    // Memory response
    word_t rdata;
    logic  rvalid;

    // Issued read and its source
    logic     rd_issue;
    src_tag_t rd_tag;

    access_arbiter access_arbiter_i (
        .f_en     (f_en),
        .f_addr   (f_addr),
        .d_en     (d_en),
        .d_wr     (d_wr),
        .d_addr   (d_addr),
        .d_wdata  (d_wdata),
        .f_stall  (f_stall),
        .req      (req_bus.arb),
        .rd_issue (rd_issue),
        .rd_tag   (rd_tag)
    );

    data_memory data_memory_i (
        .clk    (clk),
        .rst    (rst),
        .req    (req_bus.mem),
        .rdata  (rdata),
        .rvalid (rvalid)
    );

    response_router response_router_i (
        .clk      (clk),
        .rst      (rst),
        .rd_issue (rd_issue),
        .rd_tag   (rd_tag),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .f_rdata  (f_rdata),
        .f_valid  (f_valid),
        .d_rdata  (d_rdata),
        .d_valid  (d_valid)
    );

endmodule

//--- mem_subsys_props.sv
////////////////////////////////////////
// Memory subsystem properties
// Response count, port exclusion, stall
////////////////////////////////////////

`timescale 1ns/10ps

module mem_subsys_props (
    input logic clk,
    input logic rst,
    input logic f_en,
    input logic d_en,
    input logic f_stall,
    input logic f_valid,
    input logic d_valid,
    input logic rd_issue
);
    import mem_pkg::*;

    // Every issued read comes back on exactly one port
    // A reset in between drops the response
    resp_one_port: assert property (@(posedge clk) disable iff (rst)
        rd_issue |-> ##read_latency (f_valid ^ d_valid))
        else $error("Issued read did not return on exactly one port");

    // Never both ports in the same cycle
    valid_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(f_valid && d_valid))
        else $error("Fetch and data responses in the same cycle");

    // Stall only when both ports ask
    stall_on_conflict: assert property (@(posedge clk) disable iff (rst)
        f_stall |-> (f_en && d_en))
        else $error("Fetch stall without a data strobe");

endmodule

// Attach to the top level
bind mem_subsys mem_subsys_props mem_subsys_props_i (
    .clk      (clk),
    .rst      (rst),
    .f_en     (f_en),
    .d_en     (d_en),
    .f_stall  (f_stall),
    .f_valid  (f_valid),
    .d_valid  (d_valid),
    .rd_issue (rd_issue)
);

//--- response_router.sv
////////////////////////////////////////
// Response router
// Follows the read pipeline with a tag and
// steers each word to fetch or data
////////////////////////////////////////

`timescale 1ns/10ps

module response_router (
    input  logic              clk,
    input  logic              rst,
    input  logic              rd_issue,
    input  mem_pkg::src_tag_t rd_tag,
    input  mem_pkg::word_t    rdata,
    input  logic              rvalid,
    output mem_pkg::word_t    f_rdata,
    output logic              f_valid,
    output mem_pkg::word_t    d_rdata,
    output logic              d_valid
);
    import mem_pkg::*;

    // Tag shift register, same depth as the memory pipe
    src_tag_t tag_pipe [read_latency];
    src_tag_t tag_out;

    // Last word delivered to each port
    word_t f_hold;
    word_t d_hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < read_latency; i++) begin
                tag_pipe[i] <= '0;
            end
        end else begin
            // Idle cycles shift in a zero tag
            tag_pipe[0] <= rd_issue ? rd_tag : src_tag_t'(0);
            for (int i = 1; i < read_latency; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    assign tag_out = tag_pipe[read_latency-1];

    // Exactly one port sees each response
    assign f_valid = rvalid && (tag_out == src_tag_t'(0));
    assign d_valid = rvalid && (tag_out == src_tag_t'(1));

    // Unselected port keeps its last word
    always_ff @(posedge clk) begin
        if (f_valid) f_hold <= rdata;
        if (d_valid) d_hold <= rdata;
    end

    assign f_rdata = f_valid ? rdata : f_hold;
    assign d_rdata = d_valid ? rdata : d_hold;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_mem_subsys -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Checks failed" sim.log || ! grep -q "All checks passed" sim.log; then
    exit 1
fi
exit 0

//--- tb_mem_subsys.sv
////////////////////////////////////////
// Memory subsystem testbench
// Fetch and data traffic against a word
// model, checked on every response
////////////////////////////////////////

`timescale 1ns/10ps

module tb_mem_subsys;
    import mem_pkg::*;

    logic  clk;
    logic  rst;
    logic  f_en;
    addr_t f_addr;
    logic  f_stall;
    word_t f_rdata;
    logic  f_valid;
    logic  d_en;
    logic  d_wr;
    addr_t d_addr;
    word_t d_wdata;
    word_t d_rdata;
    logic  d_valid;

    // Reference image, updated by every write
    word_t model_mem [2**word_idx_w];

    // Expected words and issue cycles, one pair of queues per port
    word_t f_exp [$];
    int    f_cyc [$];
    word_t d_exp [$];
    int    d_cyc [$];

    int seed;
    // Rising edges seen so far
    int cyc = 0;
    int cmp_checks = 0;
    int cmp_errors = 0;
    int drv_checks = 0;
    int drv_errors = 0;

    mem_subsys mem_subsys_i (
        .clk     (clk),
        .rst     (rst),
        .f_en    (f_en),
        .f_addr  (f_addr),
        .f_stall (f_stall),
        .f_rdata (f_rdata),
        .f_valid (f_valid),
        .d_en    (d_en),
        .d_wr    (d_wr),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .d_rdata (d_rdata),
        .d_valid (d_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference model and random helpers
    ////////////////////////////////////////

    // Word for a byte address, bit 0 dropped
    function automatic word_t expected_word(input addr_t a);
        word_idx_t idx;
        idx = a[addr_w-1:1];
        return model_mem[idx];
    endfunction

    // Even address inside the 24 loaded words
    function automatic addr_t rand_addr();
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return addr_t'(2 * (r % 24));
    endfunction

    function automatic word_t rand_word();
        int r;
        r = $random(seed);
        return r[data_w-1:0];
    endfunction

    function automatic logic rand_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // One request cycle, model follows the arbitration rule
    task automatic drive_cycle(input logic fe, input addr_t fa, input logic de,
                               input logic dw, input addr_t da, input word_t dd);
        @(negedge clk);
        f_en    = fe;
        f_addr  = fa;
        d_en    = de;
        d_wr    = dw;
        d_addr  = da;
        d_wdata = dd;
        if (de && dw) begin
            model_mem[da[addr_w-1:1]] = dd;
        end else if (de) begin
            d_exp.push_back(expected_word(da));
            d_cyc.push_back(cyc);
        end
        // Fetch is accepted only in a cycle without a data strobe
        if (fe && !de) begin
            f_exp.push_back(expected_word(fa));
            f_cyc.push_back(cyc);
        end
    endtask

    task automatic drive_idle();
        drive_cycle(1'b0, '0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic flush_expected();
        f_exp.delete();
        f_cyc.delete();
        d_exp.delete();
        d_cyc.delete();
    endtask

    // Wait for outstanding responses, then report the test
    task automatic drain(input string name);
        int waited;
        waited = 0;
        drive_idle();
        while ((f_exp.size() + d_exp.size()) != 0 && waited < read_latency + 4) begin
            @(negedge clk);
            waited++;
        end
        drv_checks++;
        if ((f_exp.size() + d_exp.size()) != 0) begin
            drv_errors++;
            $display("Test %s: %0d responses never arrived", name,
                     f_exp.size() + d_exp.size());
            flush_expected();
        end
        $display("Test %s finished, errors so far %0d", name, cmp_errors + drv_errors);
    endtask

    task automatic check_low(input string sig, input logic v);
        drv_checks++;
        if (v !== 1'b0) begin
            drv_errors++;
            $display("FAIL %0t %s expected 0 got %b", $time, sig, v);
        end
    endtask

    ////////////////////////////////////////
    // Response comparison
    ////////////////////////////////////////

    task automatic check_word(input string sig, input word_t exp, input int issued,
                              input word_t got);
        cmp_checks++;
        if (got !== exp) begin
            cmp_errors++;
            $display("FAIL %0t %s expected %h got %h", $time, sig, exp, got);
        end
        if (cyc - issued != read_latency) begin
            cmp_errors++;
            $display("FAIL %0t %s latency expected %0d got %0d", $time, sig,
                     read_latency, cyc - issued);
        end
    endtask

    // Outputs are stable at the rising edge, inputs change on the falling one
    always @(posedge clk) begin
        if (f_stall !== (f_en && d_en)) begin
            cmp_errors++;
            $display("FAIL %0t f_stall expected %b got %b", $time, f_en && d_en, f_stall);
        end
        if (f_valid === 1'b1) begin
            if (f_exp.size() == 0) begin
                cmp_errors++;
                $display("Fetch response at %0t with no fetch read outstanding", $time);
            end else begin
                check_word("f_rdata", f_exp.pop_front(), f_cyc.pop_front(), f_rdata);
            end
        end
        if (d_valid === 1'b1) begin
            if (d_exp.size() == 0) begin
                cmp_errors++;
                $display("Data response at %0t with no data read outstanding", $time);
            end else begin
                check_word("d_rdata", d_exp.pop_front(), d_cyc.pop_front(), d_rdata);
            end
        end
        cyc++;
    end

    // Watchdog, one term per test including its drain
    initial begin
        int budget;
        budget = 2 + (24 + 9) + (20 + 9) + (16 + 9) + (80 + 9) + (12 + 9) + (24 + 9);
        #(budget * 8 + 400);
        $display("Timeout: run did not finish within %0d cycles", budget);
        $display("Checks failed");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        addr_t a;
        addr_t fa;
        addr_t keep [4];
        logic  f_pend;
        logic  de;
        seed    = 26;
        rst     = 1'b1;
        f_en    = 1'b0;
        f_addr  = '0;
        d_en    = 1'b0;
        d_wr    = 1'b0;
        d_addr  = '0;
        d_wdata = '0;
        fa      = '0;
        $readmemh(init_file, model_mem);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Whole image through the fetch port
        for (int i = 0; i < 24; i++) begin
            drive_cycle(1'b1, addr_t'(2 * i), 1'b0, 1'b0, '0, '0);
        end
        drain("1 image fetch");

        // Write, then read it back in the very next cycle
        for (int i = 0; i < 10; i++) begin
            a = rand_addr();
            drive_cycle(1'b0, '0, 1'b1, 1'b1, a, rand_word());
            drive_cycle(1'b0, '0, 1'b1, 1'b0, a, '0);
        end
        drain("2 write and read back");

        // A read every cycle, ports alternating, addresses descending
        for (int i = 0; i < 16; i++) begin
            a = addr_t'(2 * (23 - i));
            drive_cycle(i[0], a, !i[0], 1'b0, a, '0);
        end
        drain("3 back to back reads");

        // Random strobes on both ports, fetch holds while stalled
        f_pend = 1'b0;
        for (int i = 0; i < 60; i++) begin
            if (!f_pend && rand_bit()) begin
                f_pend = 1'b1;
                fa     = rand_addr();
            end
            de = rand_bit();
            drive_cycle(f_pend, fa, de, rand_bit(), rand_addr(), rand_word());
            if (!de) begin
                f_pend = 1'b0;
            end
        end
        if (f_pend) begin
            drive_cycle(1'b1, fa, 1'b0, 1'b0, '0, '0);
        end
        drain("4 random both ports");

        // Odd byte address on both ports
        for (int i = 0; i < 6; i++) begin
            a = rand_addr() | addr_t'(1);
            drive_cycle(1'b1, a, 1'b0, 1'b0, '0, '0);
            drive_cycle(1'b0, '0, 1'b1, 1'b0, a, '0);
        end
        drain("5 odd addresses");

        // Stored words, then reads left in flight across a reset
        for (int i = 0; i < 4; i++) begin
            keep[i] = addr_t'(2 * (3 + 5 * i));
            drive_cycle(1'b0, '0, 1'b1, 1'b1, keep[i], rand_word());
        end
        // Fetch, data, fetch so both ports have a response in the pipe
        for (int i = 0; i < 3; i++) begin
            drive_cycle(!i[0], addr_t'(2 * i), i[0], 1'b0, addr_t'(2 * i), '0);
        end
        drive_idle();
        // Reset drops whatever is still in the pipe
        rst = 1'b1;
        flush_expected();
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            check_low("f_valid", f_valid);
            check_low("d_valid", d_valid);
        end
        rst = 1'b0;
        repeat (read_latency + 1) drive_idle();
        for (int i = 0; i < 4; i++) begin
            drive_cycle(1'b0, '0, 1'b1, 1'b0, keep[i], '0);
        end
        drain("6 reset in mid run");

        $display("Summary: %0d checks, %0d errors", cmp_checks + drv_checks,
                 cmp_errors + drv_errors);
        if (cmp_errors + drv_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
